// ==== verilog/load_pkg.sv ====
// load operation encoding, data widths, issue-side request and load buffer entry types
package load_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------

  // register and data path width
  localparam int unsigned xlen = 64;
  // byte offset bits within one xlen word
  localparam int unsigned xlen_align_bytes = 3;
  // scoreboard transaction id
  localparam int unsigned trans_id_bits = 3;
  // address width, virtual and physical are the same here
  localparam int unsigned vlen = 39;

  // ----------------------------------------------------------------------
  // load operations
  // ----------------------------------------------------------------------

  typedef enum logic [3:0] {
    LD,
    LW,
    LWU,
    LH,
    LHU,
    LB,
    LBU
  } ld_op_e;

  // request as presented by the issue queue
  typedef struct packed {
    logic [vlen-1:0]          vaddr;
    logic [7:0]               be;
    ld_op_e                   operation;
    logic [trans_id_bits-1:0] trans_id;
  } lsu_ctrl_t;

  // what must be remembered per outstanding load until its data returns
  typedef struct packed {
    logic [trans_id_bits-1:0]    trans_id;
    logic [xlen_align_bytes-1:0] address_offset;
    ld_op_e                      operation;
  } ldbuf_entry_t;

  // cache transfer size, log2 of the number of bytes
  function automatic logic [1:0] transfer_size(ld_op_e op);
    case (op)
      LW, LWU: return 2'b10;
      LH, LHU: return 2'b01;
      LB, LBU: return 2'b00;
      default: return 2'b11;
    endcase
  endfunction

endpackage

// ==== verilog/dcache_pkg.sv ====
// data cache geometry constants and cache request and response structs
package dcache_pkg;

  // ----------------------------------------------------------------------
  // geometry
  // ----------------------------------------------------------------------

  // index covers the 4 KiB page offset
  localparam int unsigned index_width = 12;
  // remaining address bits above the index
  localparam int unsigned tag_width = 27;
  // request id, wide enough for every load buffer slot
  localparam int unsigned data_id_width = 4;

  // ----------------------------------------------------------------------
  // port structs
  // ----------------------------------------------------------------------

  // load unit to cache
  typedef struct packed {
    logic                         data_req;
    logic [index_width-1:0]       address_index;
    logic [tag_width-1:0]         address_tag;
    logic [load_pkg::xlen/8-1:0]  data_be;
    logic [1:0]                   data_size;
    logic [data_id_width-1:0]     data_id;
    logic                         kill_req;
    logic                         tag_valid;
  } dcache_req_t;

  // cache to load unit
  typedef struct packed {
    logic                      data_gnt;
    logic                      data_rvalid;
    logic [data_id_width-1:0]  data_rid;
    logic [load_pkg::xlen-1:0] data_rdata;
  } dcache_rsp_t;

endpackage

// ==== verilog/load_buffer.sv ====
// load buffer: table of outstanding loads with free-slot search, flushed flags, lookup
module load_buffer #(
  parameter int unsigned nr_ldbuf_entries = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  // new outstanding load, written to windex_o
  input  logic                                 alloc_i,
  input  load_pkg::ldbuf_entry_t               entry_i,
  // cache response lookup
  input  logic                                 rvalid_i,
  input  logic [dcache_pkg::data_id_width-1:0] rid_i,
  output logic                                 full_o,
  output logic [$clog2(nr_ldbuf_entries)-1:0]  windex_o,
  output load_pkg::ldbuf_entry_t               entry_o,
  output logic                                 flushed_o
);

  localparam int unsigned id_bits = $clog2(nr_ldbuf_entries);

  logic [nr_ldbuf_entries-1:0] valid_q, valid_d;
  logic [nr_ldbuf_entries-1:0] flushed_q, flushed_d;
  load_pkg::ldbuf_entry_t [nr_ldbuf_entries-1:0] entries_q;
  logic [id_bits-1:0] rindex;

  // response id is the slot number
  assign rindex = rid_i[id_bits-1:0];

  assign full_o    = &valid_q;
  assign entry_o   = entries_q[rindex];
  assign flushed_o = flushed_q[rindex];

  // ----------------------------------------------------------------------
  // free slot search
  // ----------------------------------------------------------------------

  // walk from the top so the lowest free slot is the one left standing
  always_comb begin
    windex_o = '0;
    for (int i = nr_ldbuf_entries - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        windex_o = id_bits'(i);
      end
    end
  end

  // ----------------------------------------------------------------------
  // valid and flushed bookkeeping
  // ----------------------------------------------------------------------

  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // response frees its slot, reusable next cycle
    if (rvalid_i) begin
      valid_d[rindex] = 1'b0;
    end
    if (alloc_i) begin
      valid_d[windex_o]   = 1'b1;
      flushed_d[windex_o] = 1'b0;
    end
    // flush last so a load accepted in the flush cycle is dropped too
    if (flush_i) begin
      flushed_d = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
    end
  end

  // payload only, qualified by valid_q
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      entries_q[windex_o] <= entry_i;
    end
  end

endmodule

// ==== verilog/load_ctrl_fsm.sv ====
// load request FSM: page-offset stall, grant wait, tag send and flush kill
module load_ctrl_fsm #(
  parameter int unsigned nr_ldbuf_entries = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                flush_i,
  // issue side
  input  logic                                valid_i,
  input  load_pkg::lsu_ctrl_t                 lsu_ctrl_i,
  input  logic                                page_offset_matches_i,
  // load buffer state
  input  logic                                ldbuf_full_i,
  input  logic [$clog2(nr_ldbuf_entries)-1:0] ldbuf_windex_i,
  // cache side
  input  dcache_pkg::dcache_rsp_t             req_port_i,
  output logic                                alloc_o,
  output logic [$clog2(nr_ldbuf_entries)-1:0] last_id_o,
  output logic                                pop_ld_o,
  output dcache_pkg::dcache_req_t             req_port_o
);

  localparam int unsigned id_bits = $clog2(nr_ldbuf_entries);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_PAGE_OFFSET,
    WAIT_GNT,
    SEND_TAG,
    WAIT_FLUSH
  } state_e;

  state_e state_q, state_d;
  logic [dcache_pkg::tag_width-1:0] tag_q;
  logic [id_bits-1:0] last_id_q;

  // ----------------------------------------------------------------------
  // next state and cache request
  // ----------------------------------------------------------------------

  always_comb begin
    state_d  = state_q;
    alloc_o  = 1'b0;
    pop_ld_o = 1'b0;
    // index and size come straight from the pending request
    req_port_o.data_req      = 1'b0;
    req_port_o.address_index = lsu_ctrl_i.vaddr[dcache_pkg::index_width-1:0];
    req_port_o.address_tag   = tag_q;
    req_port_o.data_be       = lsu_ctrl_i.be;
    req_port_o.data_size     = load_pkg::transfer_size(lsu_ctrl_i.operation);
    // request id is the slot the load will occupy
    req_port_o.data_id       = dcache_pkg::data_id_width'(ldbuf_windex_i);
    req_port_o.kill_req      = 1'b0;
    req_port_o.tag_valid     = 1'b0;

    case (state_q)
      // SEND_TAG finishes the previous load and may start the next one
      IDLE, SEND_TAG: begin
        req_port_o.tag_valid = (state_q == SEND_TAG);
        state_d = IDLE;
        // a full buffer holds the request off entirely
        if (valid_i && !ldbuf_full_i) begin
          if (page_offset_matches_i) begin
            // older store to the same offset, wait for it to drain
            state_d = WAIT_PAGE_OFFSET;
          end else begin
            req_port_o.data_req = 1'b1;
            if (req_port_i.data_gnt) begin
              alloc_o  = 1'b1;
              pop_ld_o = 1'b1;
              state_d  = SEND_TAG;
            end else begin
              state_d = WAIT_GNT;
            end
          end
        end
      end

      WAIT_PAGE_OFFSET: begin
        // request goes out the cycle after the hazard clears
        if (!page_offset_matches_i) begin
          state_d = WAIT_GNT;
        end
      end

      WAIT_GNT: begin
        // hold data_req until the cache takes it
        req_port_o.data_req = 1'b1;
        if (req_port_i.data_gnt) begin
          alloc_o  = 1'b1;
          pop_ld_o = 1'b1;
          state_d  = SEND_TAG;
        end
      end

      WAIT_FLUSH: begin
        // kill whatever the cache accepted last
        req_port_o.kill_req  = 1'b1;
        req_port_o.tag_valid = 1'b1;
        state_d = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // flush wins over any other transition
    if (flush_i) begin
      state_d = WAIT_FLUSH;
    end
  end

  // ----------------------------------------------------------------------
  // state, last slot and tag registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      last_id_q <= '0;
    end else begin
      state_q <= state_d;
      if (alloc_o) begin
        last_id_q <= ldbuf_windex_i;
      end
    end
  end

  // the issue queue advances at the grant, so keep the tag for the next cycle
  always_ff @(posedge clk_i) begin
    if (alloc_o) begin
      tag_q <= lsu_ctrl_i.vaddr[dcache_pkg::index_width +: dcache_pkg::tag_width];
    end
  end

  assign last_id_o = last_id_q;

endmodule

// ==== verilog/load_align.sv ====
// load data realignment with sign or zero extension per load operation
module load_align (
  input  logic [load_pkg::xlen-1:0] rdata_i,
  input  load_pkg::ldbuf_entry_t    entry_i,
  output logic [load_pkg::xlen-1:0] result_o
);

  // top byte of a word and of a half, relative to the start offset
  localparam logic [load_pkg::xlen_align_bytes-1:0] word_top = 3;
  localparam logic [load_pkg::xlen_align_bytes-1:0] half_top = 1;

  logic [load_pkg::xlen-1:0] shifted_data;
  logic [load_pkg::xlen/8-1:0] byte_sign_bits;
  logic [load_pkg::xlen_align_bytes-1:0] sign_offset;
  logic is_signed;
  logic sign_bit;

  // move the addressed byte down to bit 0
  assign shifted_data = rdata_i >> {entry_i.address_offset, 3'b000};

  // msb of every byte, picked in parallel with the shifter
  for (genvar i = 0; i < load_pkg::xlen / 8; i++) begin : gen_sign_bits
    assign byte_sign_bits[i] = rdata_i[8*i+7];
  end

  assign is_signed = entry_i.operation inside {load_pkg::LW, load_pkg::LH, load_pkg::LB};

  always_comb begin
    case (entry_i.operation)
      load_pkg::LW:  sign_offset = entry_i.address_offset + word_top;
      load_pkg::LH:  sign_offset = entry_i.address_offset + half_top;
      default:       sign_offset = entry_i.address_offset;
    endcase
  end

  // unsigned variants pull the fill to zero
  assign sign_bit = is_signed & byte_sign_bits[sign_offset];

  // ----------------------------------------------------------------------
  // result mux
  // ----------------------------------------------------------------------

  always_comb begin
    case (entry_i.operation)
      load_pkg::LW, load_pkg::LWU: begin
        result_o = {{load_pkg::xlen-32{sign_bit}}, shifted_data[31:0]};
      end
      load_pkg::LH, load_pkg::LHU: begin
        result_o = {{load_pkg::xlen-16{sign_bit}}, shifted_data[15:0]};
      end
      load_pkg::LB, load_pkg::LBU: begin
        result_o = {{load_pkg::xlen-8{sign_bit}}, shifted_data[7:0]};
      end
      // LD is the full word as returned
      default: begin
        result_o = shifted_data;
      end
    endcase
  end

endmodule

// ==== verilog/load_unit.sv ====
// load unit top level: load buffer, request FSM and data aligner on issue and cache ports
module load_unit #(
  parameter int unsigned nr_ldbuf_entries = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  // issue queue
  input  logic                                  valid_i,
  input  load_pkg::lsu_ctrl_t                   lsu_ctrl_i,
  output logic                                  pop_ld_o,
  // writeback
  output logic                                  valid_o,
  output logic [load_pkg::trans_id_bits-1:0]    trans_id_o,
  output logic [load_pkg::xlen-1:0]             result_o,
  // store side address check
  output logic [11:0]                           page_offset_o,
  input  logic                                  page_offset_matches_i,
  // data cache
  input  dcache_pkg::dcache_rsp_t               req_port_i,
  output dcache_pkg::dcache_req_t               req_port_o
);

  localparam int unsigned id_bits = $clog2(nr_ldbuf_entries);

  logic                   ldbuf_alloc;
  logic                   ldbuf_full;
  logic [id_bits-1:0]     ldbuf_windex;
  logic [id_bits-1:0]     last_id;
  load_pkg::ldbuf_entry_t ldbuf_wentry;
  load_pkg::ldbuf_entry_t ldbuf_rentry;
  logic                   ldbuf_rflushed;

  // low 12 bits are the same before and after translation
  assign page_offset_o = lsu_ctrl_i.vaddr[11:0];

  // only what is needed to format the result later
  assign ldbuf_wentry.trans_id       = lsu_ctrl_i.trans_id;
  assign ldbuf_wentry.address_offset = lsu_ctrl_i.vaddr[load_pkg::xlen_align_bytes-1:0];
  assign ldbuf_wentry.operation      = lsu_ctrl_i.operation;

  // ----------------------------------------------------------------------
  // submodules
  // ----------------------------------------------------------------------

  load_ctrl_fsm #(
    .nr_ldbuf_entries (nr_ldbuf_entries)
  ) ctrl_i (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .lsu_ctrl_i            (lsu_ctrl_i),
    .page_offset_matches_i (page_offset_matches_i),
    .ldbuf_full_i          (ldbuf_full),
    .ldbuf_windex_i        (ldbuf_windex),
    .req_port_i            (req_port_i),
    .alloc_o               (ldbuf_alloc),
    .last_id_o             (last_id),
    .pop_ld_o              (pop_ld_o),
    .req_port_o            (req_port_o)
  );

  load_buffer #(
    .nr_ldbuf_entries (nr_ldbuf_entries)
  ) ldbuf_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .alloc_i   (ldbuf_alloc),
    .entry_i   (ldbuf_wentry),
    .rvalid_i  (req_port_i.data_rvalid),
    .rid_i     (req_port_i.data_rid),
    .full_o    (ldbuf_full),
    .windex_o  (ldbuf_windex),
    .entry_o   (ldbuf_rentry),
    .flushed_o (ldbuf_rflushed)
  );

  load_align align_i (
    .rdata_i  (req_port_i.data_rdata),
    .entry_i  (ldbuf_rentry),
    .result_o (result_o)
  );

  // ----------------------------------------------------------------------
  // writeback
  // ----------------------------------------------------------------------

  assign trans_id_o = ldbuf_rentry.trans_id;

  // drop flushed loads, and the last issued one while it is being killed
  always_comb begin
    valid_o = 1'b0;
    if (req_port_i.data_rvalid && !ldbuf_rflushed) begin
      if ((last_id != req_port_i.data_rid[id_bits-1:0]) || !req_port_o.kill_req) begin
        valid_o = 1'b1;
      end
    end
  end

endmodule

// ==== verification/tb_load_unit.sv ====
// load unit testbench with clock, reset, cache model, stimulus tasks, checks and report
module tb_load_unit;

  localparam int unsigned nr_entries  = 4;
  localparam int unsigned clk_period  = 100;
  localparam int unsigned drive_delay = 10;
  localparam int unsigned num_tests   = 5;
  localparam int unsigned nr_ids      = 2 ** dcache_pkg::data_id_width;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               flush_i;
  logic                               valid_i;
  load_pkg::lsu_ctrl_t                lsu_ctrl_i;
  logic                               pop_ld_o;
  logic                               valid_o;
  logic [load_pkg::trans_id_bits-1:0] trans_id_o;
  logic [load_pkg::xlen-1:0]          result_o;
  logic [11:0]                        page_offset_o;
  logic                               page_offset_matches_i;
  dcache_pkg::dcache_rsp_t            req_port_i;
  dcache_pkg::dcache_req_t            req_port_o;

  // run bookkeeping
  int unsigned errors, accepts, dropped, reordered, tests_run, outstanding;
  int unsigned err_start, acc_start, reord_start;
  logic [31:0] model_rand, stim_rand;

  // expected state per cache request id
  logic                               exp_valid   [nr_ids];
  logic                               exp_flushed [nr_ids];
  logic [load_pkg::trans_id_bits-1:0] exp_tid     [nr_ids];
  logic [5:0]                         exp_addr    [nr_ids];
  load_pkg::ld_op_e                   exp_op      [nr_ids];
  logic [dcache_pkg::data_id_width-1:0] accept_order [$];

  // per-cycle protocol expectations
  logic tag_due, kill_due, req_waiting;
  logic [dcache_pkg::tag_width-1:0] tag_expected;

  // cache model state
  logic [63:0] mem [8];
  logic        hold_rsp;
  int unsigned gnt_wait;
  logic        rsp_pending [nr_ids];
  int unsigned rsp_wait    [nr_ids];
  logic [2:0]  rsp_word    [nr_ids];

  load_unit #(
    .nr_ldbuf_entries (nr_entries)
  ) dut_i (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .lsu_ctrl_i            (lsu_ctrl_i),
    .pop_ld_o              (pop_ld_o),
    .valid_o               (valid_o),
    .trans_id_o            (trans_id_o),
    .result_o              (result_o),
    .page_offset_o         (page_offset_o),
    .page_offset_matches_i (page_offset_matches_i),
    .req_port_i            (req_port_i),
    .req_port_o            (req_port_o)
  );

  initial clk_i = 1'b0;
  always #(clk_period / 2) clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  function automatic logic [31:0] lcg(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] stim_next();
    stim_rand = lcg(stim_rand);
    return stim_rand;
  endfunction

  // memory contents with every byte a function of its full address
  function automatic logic [7:0] mem_byte(input logic [5:0] addr);
    return addr * 8'd37 + 8'h83;
  endfunction

  function automatic int unsigned op_bytes(input load_pkg::ld_op_e op);
    case (op)
      load_pkg::LD:                return 8;
      load_pkg::LW, load_pkg::LWU: return 4;
      load_pkg::LH, load_pkg::LHU: return 2;
      default:                     return 1;
    endcase
  endfunction

  // log2 of the access width in bytes
  function automatic logic [1:0] size_code(input load_pkg::ld_op_e op);
    case (op_bytes(op))
      8:       return 2'd3;
      4:       return 2'd2;
      2:       return 2'd1;
      default: return 2'd0;
    endcase
  endfunction

  // gather the loaded bytes, then fill the upper bytes with the sign or zero
  function automatic logic [63:0] load_value(input logic [5:0] addr, input load_pkg::ld_op_e op);
    int unsigned nbytes;
    logic        fill;
    logic [63:0] value;
    nbytes = op_bytes(op);
    value  = '0;
    for (int k = 0; k < nbytes; k++) begin
      value[8*k +: 8] = mem_byte(6'(addr + k));
    end
    fill = (op inside {load_pkg::LW, load_pkg::LH, load_pkg::LB}) && value[8*nbytes-1];
    for (int k = nbytes; k < 8; k++) begin
      value[8*k +: 8] = {8{fill}};
    end
    return value;
  endfunction

  function automatic void value_error(input string name, input logic [63:0] got,
                                      input logic [63:0] exp);
    $display("** Error: %s = %h, expected %h at time %0t", name, got, exp, $time);
    errors++;
  endfunction

  function automatic void report_failure(input string what);
    $display("error: %s at time %0t", what, $time);
    errors++;
  endfunction

  function automatic logic [38:0] random_vaddr(input logic [2:0] offset);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = stim_next();
    lo = stim_next();
    return {hi[31:5], lo[24:16], offset};
  endfunction

  // ----------------------------------------------------------------------
  // cache model driven a fixed delay after the rising edge
  // ----------------------------------------------------------------------

  always @(posedge clk_i) begin : drive_cache
    logic       found;
    logic [3:0] slot;
    logic [3:0] pick;
    #drive_delay;
    req_port_i.data_gnt    = (gnt_wait == 0);
    req_port_i.data_rvalid = 1'b0;
    req_port_i.data_rid    = '0;
    req_port_i.data_rdata  = '0;
    found = 1'b0;
    pick  = '0;
    model_rand = lcg(model_rand);
    if (!hold_rsp) begin
      // random start point so ready responses leave out of order
      for (int k = 0; k < nr_ids; k++) begin
        slot = 4'(model_rand[19:16] + k);
        if (!found && rsp_pending[slot] && rsp_wait[slot] == 0) begin
          found = 1'b1;
          pick  = slot;
        end
      end
      if (found) begin
        rsp_pending[pick]      = 1'b0;
        req_port_i.data_rvalid = 1'b1;
        req_port_i.data_rid    = pick;
        req_port_i.data_rdata  = mem[rsp_word[pick]];
      end
    end
  end

  // ----------------------------------------------------------------------
  // checks and model bookkeeping sampled mid-cycle
  // ----------------------------------------------------------------------

  always @(negedge clk_i) begin : sample_cycle
    logic [dcache_pkg::data_id_width-1:0] id;
    logic removed;
    if (rst_ni) begin
      assert (!pop_ld_o || (req_port_o.data_req && req_port_i.data_gnt))
        else report_failure("pop_ld_o high without data_req and data_gnt");
      if (req_waiting) begin
        assert (req_port_o.data_req) else report_failure("data_req dropped before its grant");
      end
      if (tag_due) begin
        assert (req_port_o.tag_valid) else report_failure("tag_valid missing after a grant");
        assert (req_port_o.address_tag == tag_expected)
          else value_error("address_tag", 64'(req_port_o.address_tag), 64'(tag_expected));
      end
      if (kill_due) begin
        assert (req_port_o.kill_req && req_port_o.tag_valid)
          else report_failure("kill_req with tag_valid missing after a flush");
      end
      // store hazard holds the request back
      if (page_offset_matches_i) begin
        assert (!req_port_o.data_req && !pop_ld_o)
          else report_failure("load sent while its page offset matched a store");
        assert (page_offset_o == lsu_ctrl_i.vaddr[11:0])
          else value_error("page_offset_o", 64'(page_offset_o), 64'(lsu_ctrl_i.vaddr[11:0]));
      end
      if (outstanding == nr_entries) begin
        assert (!req_port_o.data_req)
          else report_failure("data_req raised with every buffer slot in use");
      end

      // response side
      if (req_port_i.data_rvalid) begin
        id = req_port_i.data_rid;
        if (exp_flushed[id]) begin
          assert (!valid_o) else report_failure("flushed load produced valid_o");
          dropped++;
        end else begin
          assert (valid_o) else report_failure("valid_o missing for a cache response");
          assert (trans_id_o == exp_tid[id])
            else value_error("trans_id_o", 64'(trans_id_o), 64'(exp_tid[id]));
          assert (result_o == load_value(exp_addr[id], exp_op[id]))
            else value_error("result_o", result_o, load_value(exp_addr[id], exp_op[id]));
        end
        if (accept_order.size() > 0 && accept_order[0] != id) begin
          reordered++;
        end
        removed = 1'b0;
        for (int i = 0; i < accept_order.size(); i++) begin
          if (!removed && accept_order[i] == id) begin
            accept_order.delete(i);
            removed = 1'b1;
          end
        end
        exp_valid[id] = 1'b0;
        outstanding--;
      end else begin
        assert (!valid_o) else report_failure("valid_o without a cache response");
      end

      // response latency countdown
      for (int i = 0; i < nr_ids; i++) begin
        if (rsp_pending[i] && rsp_wait[i] > 0) begin
          rsp_wait[i]--;
        end
      end

      // accept side
      tag_due  = 1'b0;
      kill_due = flush_i;
      if (req_port_o.data_req && req_port_i.data_gnt) begin
        id = req_port_o.data_id;
        assert (!exp_valid[id]) else report_failure("request id reused while outstanding");
        assert (req_port_o.address_index == lsu_ctrl_i.vaddr[11:0])
          else value_error("address_index", 64'(req_port_o.address_index),
                           64'(lsu_ctrl_i.vaddr[11:0]));
        assert (req_port_o.data_be == lsu_ctrl_i.be)
          else value_error("data_be", 64'(req_port_o.data_be), 64'(lsu_ctrl_i.be));
        assert (req_port_o.data_size == size_code(lsu_ctrl_i.operation))
          else value_error("data_size", 64'(req_port_o.data_size),
                           64'(size_code(lsu_ctrl_i.operation)));
        exp_valid[id]   = 1'b1;
        exp_flushed[id] = 1'b0;
        exp_tid[id]     = lsu_ctrl_i.trans_id;
        exp_addr[id]    = lsu_ctrl_i.vaddr[5:0];
        exp_op[id]      = lsu_ctrl_i.operation;
        tag_expected    = lsu_ctrl_i.vaddr[38:12];
        tag_due         = 1'b1;
        accept_order.push_back(id);
        outstanding++;
        accepts++;
        // grant delay of 0 to 3 and response latency of 1 to 6
        model_rand      = lcg(model_rand);
        gnt_wait        = model_rand[17:16];
        model_rand      = lcg(model_rand);
        rsp_wait[id]    = model_rand[23:16] % 6;
        rsp_word[id]    = req_port_o.address_index[5:3];
        rsp_pending[id] = 1'b1;
      end else if (req_port_o.data_req && gnt_wait > 0) begin
        gnt_wait--;
      end
      req_waiting = req_port_o.data_req && !req_port_i.data_gnt && !flush_i;
      if (flush_i) begin
        for (int i = 0; i < nr_ids; i++) begin
          if (exp_valid[i]) begin
            exp_flushed[i] = 1'b1;
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  task automatic next_drive();
    @(posedge clk_i);
    #drive_delay;
  endtask

  // hold changes mid-cycle away from the model drive point
  task automatic set_hold(input logic value);
    @(negedge clk_i);
    hold_rsp = value;
    next_drive();
  endtask

  task automatic present_load(input logic [38:0] vaddr, input load_pkg::ld_op_e op,
                              input logic [2:0] tid, input int unsigned hazard_cycles);
    lsu_ctrl_i.vaddr      = vaddr;
    lsu_ctrl_i.be         = 8'(((1 << op_bytes(op)) - 1) << vaddr[2:0]);
    lsu_ctrl_i.operation  = op;
    lsu_ctrl_i.trans_id   = tid;
    valid_i               = 1'b1;
    page_offset_matches_i = (hazard_cycles > 0);
  endtask

  // keep the request up until the pop while the store match clears on schedule
  task automatic wait_pop(input int unsigned hazard_cycles);
    logic popped;
    popped = 1'b0;
    while (!popped) begin
      @(negedge clk_i);
      popped = pop_ld_o;
      next_drive();
      if (hazard_cycles > 0) begin
        hazard_cycles--;
      end
      page_offset_matches_i = (hazard_cycles > 0);
    end
    valid_i               = 1'b0;
    page_offset_matches_i = 1'b0;
  endtask

  task automatic issue_load(input logic [38:0] vaddr, input load_pkg::ld_op_e op,
                            input logic [2:0] tid, input int unsigned hazard_cycles);
    present_load(vaddr, op, tid, hazard_cycles);
    wait_pop(hazard_cycles);
  endtask

  task automatic issue_random_load(input int unsigned hazard_cycles);
    logic [31:0]      r;
    load_pkg::ld_op_e op;
    logic [2:0]       offset;
    r      = stim_next();
    op     = load_pkg::ld_op_e'(r[23:16] % 7);
    offset = r[26:24] & ~3'(op_bytes(op) - 1);
    issue_load(random_vaddr(offset), op, r[30:28], hazard_cycles);
  endtask

  // counters at the start of a test
  function automatic void start_test();
    err_start   = errors;
    acc_start   = accepts;
    reord_start = reordered;
  endfunction

  // wait for all responses, then print the test line
  task automatic end_test(input string name, input logic need_reorder);
    while (outstanding != 0) begin
      next_drive();
    end
    repeat (2) next_drive();
    if (need_reorder) begin
      assert (reordered > reord_start)
        else report_failure("no response came back out of order");
    end
    tests_run++;
    $display("test %s loads %0d, reordered responses %0d, errors %0d", name,
             accepts - acc_start, reordered - reord_start, errors - err_start);
  endtask

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------

  initial begin
    load_pkg::ld_op_e op;
    errors       = 0;
    accepts      = 0;
    dropped      = 0;
    reordered    = 0;
    tests_run    = 0;
    outstanding  = 0;
    err_start    = 0;
    acc_start    = 0;
    reord_start  = 0;
    model_rand   = 32'h3fb3_4b58;
    stim_rand    = 32'h3fb3_4b58;
    tag_due      = 1'b0;
    kill_due     = 1'b0;
    req_waiting  = 1'b0;
    tag_expected = '0;
    hold_rsp     = 1'b0;
    gnt_wait     = 0;
    for (int i = 0; i < nr_ids; i++) begin
      exp_valid[i]   = 1'b0;
      exp_flushed[i] = 1'b0;
      rsp_pending[i] = 1'b0;
      rsp_wait[i]    = 0;
    end
    for (int w = 0; w < 8; w++) begin
      for (int b = 0; b < 8; b++) begin
        mem[w][8*b +: 8] = mem_byte(6'(8 * w + b));
      end
    end
    rst_ni                = 1'b0;
    flush_i               = 1'b0;
    valid_i               = 1'b0;
    lsu_ctrl_i            = '0;
    page_offset_matches_i = 1'b0;
    req_port_i            = '0;
    repeat (16) @(posedge clk_i);
    #drive_delay;
    rst_ni = 1'b1;
    next_drive();

    // every operation at every aligned offset
    start_test();
    for (int o = 0; o < 7; o++) begin
      op = load_pkg::ld_op_e'(o);
      for (int off = 0; off < 8; off += op_bytes(op)) begin
        issue_load(random_vaddr(3'(off)), op, 3'(o + off), 0);
      end
    end
    end_test("align", 1'b0);

    // random stream with responses coming back out of order
    start_test();
    repeat (24) issue_random_load(0);
    end_test("reorder", 1'b1);

    // pending store to the same page offset
    start_test();
    issue_random_load(3);
    issue_random_load(5);
    issue_random_load(0);
    issue_random_load(2);
    end_test("hazard", 1'b0);

    // loads outstanding at the flush are dropped while later ones return
    start_test();
    set_hold(1'b1);
    repeat (3) issue_random_load(0);
    flush_i = 1'b1;
    next_drive();
    flush_i = 1'b0;
    set_hold(1'b0);
    repeat (4) issue_random_load(0);
    end_test("flush", 1'b0);

    // fill every slot, then one more must wait for a response
    start_test();
    set_hold(1'b1);
    repeat (nr_entries) issue_random_load(0);
    present_load(random_vaddr(3'b000), load_pkg::LD, 3'd5, 0);
    repeat (20) next_drive();
    set_hold(1'b0);
    wait_pop(0);
    end_test("capacity", 1'b0);

    $display("tests %0d, loads %0d, dropped %0d, errors %0d", tests_run, accepts, dropped,
             errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // run limit scales with the number of tests
  initial begin
    #(num_tests * 400 * clk_period);
    $display("watchdog expired after %0d cycles, a test did not complete", num_tests * 400);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== files.f ====
verilog/load_pkg.sv
verilog/dcache_pkg.sv
verilog/load_buffer.sv
verilog/load_ctrl_fsm.sv
verilog/load_align.sv
verilog/load_unit.sv
verification/tb_load_unit.sv

// ==== Bender.yml ====
package:
  name: load_unit

sources:
  - verilog/load_pkg.sv
  - verilog/dcache_pkg.sv
  - verilog/load_buffer.sv
  - verilog/load_ctrl_fsm.sv
  - verilog/load_align.sv
  - verilog/load_unit.sv
  - target: test
    files:
      - verification/tb_load_unit.sv
